//--- design/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

  // Packet and field widths
  localparam int packet_width = 104;
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int ctrl_width = 4;

  // Local memory word is two data words wide
  localparam int mem_width = 2 * data_width;
  localparam int lane_count = mem_width / 8;

  // Crossing FIFO geometry
  localparam int fifo_depth = 16;
  localparam int fifo_addr_width = 4;

  // Local memory geometry, index taken from dstaddr bits 8 to 3
  localparam int mem_depth = 64;
  localparam int mem_index_width = 6;
  localparam int idx_lsb = 3;

  // Address window, compared with the top bits of dstaddr
  localparam int win_width = 12;
  localparam logic [win_width-1:0] core_base = 12'h810;

  // Datamode codes
  localparam logic [1:0] dm_byte = 2'b00;
  localparam logic [1:0] dm_half = 2'b01;
  localparam logic [1:0] dm_word = 2'b10;
  localparam logic [1:0] dm_double = 2'b11;

  // Mesh packet, two views over the same 104 bits
  // Low 39 bits are common to both views
  typedef union packed {
    struct packed {
      logic reserved;
      logic [addr_width-1:0] srcaddr;
      logic [data_width-1:0] data;
      logic [addr_width-1:0] dstaddr;
      logic [ctrl_width-1:0] ctrlmode;
      logic [1:0] datamode;
      logic write;
    } plain;
    // Double view, upper data word sits where srcaddr lives
    struct packed {
      logic reserved;
      logic [mem_width-1:0] data64;
      logic [addr_width-1:0] dstaddr;
      logic [ctrl_width-1:0] ctrlmode;
      logic [1:0] datamode;
      logic write;
    } dbl;
  } emesh_packet_t;

endpackage

`default_nettype wire

//--- design/fifo_async.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_async (
  // Write side
  input  wire logic wr_clk,
  input  wire logic wr_rst,
  input  wire logic wr_en,
  input  wire logic [emesh_pkg::packet_width-1:0] din,
  output logic full,
  // Read side
  input  wire logic rd_clk,
  input  wire logic rd_rst,
  input  wire logic rd_en,
  output logic [emesh_pkg::packet_width-1:0] dout,
  output logic empty
);

  // Storage, written in wr_clk and read in rd_clk
  logic [emesh_pkg::packet_width-1:0] mem [0:emesh_pkg::fifo_depth-1];

  // Write domain pointers
  logic [emesh_pkg::fifo_addr_width:0] wr_bin;
  logic [emesh_pkg::fifo_addr_width:0] wr_bin_next;
  logic [emesh_pkg::fifo_addr_width:0] wr_gray;
  logic [emesh_pkg::fifo_addr_width:0] wr_gray_next;
  logic [emesh_pkg::fifo_addr_width:0] rd_gray_s1;
  logic [emesh_pkg::fifo_addr_width:0] rd_gray_s2;

  // Read domain pointers
  logic [emesh_pkg::fifo_addr_width:0] rd_bin;
  logic [emesh_pkg::fifo_addr_width:0] rd_bin_next;
  logic [emesh_pkg::fifo_addr_width:0] rd_gray;
  logic [emesh_pkg::fifo_addr_width:0] rd_gray_next;
  logic [emesh_pkg::fifo_addr_width:0] wr_gray_s1;
  logic [emesh_pkg::fifo_addr_width:0] wr_gray_s2;

  logic wr_fire;
  logic rd_fire;

  // Overflow and underflow are blocked here
  assign wr_fire = wr_en & ~full;
  assign rd_fire = rd_en & ~empty;

  assign wr_bin_next = wr_bin + 1'b1;
  assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);
  assign rd_bin_next = rd_bin + 1'b1;
  assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

  // Full when top two gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_s2[emesh_pkg::fifo_addr_width -: 2],
                             rd_gray_s2[emesh_pkg::fifo_addr_width-2:0]});

  // Empty when pointers match exactly
  assign empty = (rd_gray == wr_gray_s2);

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      wr_bin <= '0;
      wr_gray <= '0;
    end else if (wr_fire) begin
      wr_bin <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  // Read pointer into write domain
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wr_bin[emesh_pkg::fifo_addr_width-1:0]] <= din;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_bin <= '0;
      rd_gray <= '0;
    end else if (rd_fire) begin
      rd_bin <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  // Write pointer into read domain
  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  // Registered read word, holds between pops
  always_ff @(posedge rd_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_bin[emesh_pkg::fifo_addr_width-1:0]];
    end
  end

endmodule

`default_nettype wire

//--- design/fifo_cdc.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_cdc (
  // Incoming packet, clk_in domain
  input  wire logic clk_in,
  input  wire logic reset_in,
  input  wire logic access_in,
  input  wire logic [emesh_pkg::packet_width-1:0] packet_in,
  output logic wait_out,
  // Outgoing packet, clk_out domain
  input  wire logic clk_out,
  input  wire logic reset_out,
  output logic access_out,
  output logic [emesh_pkg::packet_width-1:0] packet_out,
  input  wire logic wait_in
);

  logic full;
  logic empty;
  logic rd_en;
  logic slot_free;

  // Sender holds access and packet while full
  assign wait_out = full;

  // Held word is free when nothing is out or it is taken now
  assign slot_free = ~access_out | ~wait_in;
  assign rd_en = ~empty & slot_free;

  // Access stays high until acknowledged by wait_in low
  always_ff @(posedge clk_out) begin
    if (reset_out) begin
      access_out <= 1'b0;
    end else if (slot_free) begin
      access_out <= rd_en;
    end
  end

  // FIFO output register doubles as the held packet
  fifo_async i_fifo_async (
    .wr_clk (clk_in),
    .wr_rst (reset_in),
    .wr_en  (access_in),
    .din    (packet_in),
    .full   (full),
    .rd_clk (clk_out),
    .rd_rst (reset_out),
    .rd_en  (rd_en),
    .dout   (packet_out),
    .empty  (empty)
  );

endmodule

`default_nettype wire

//--- design/emesh_decode.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_decode (
  input  wire logic clk_out,
  input  wire logic reset_out,
  input  wire logic stall,
  input  wire logic pop_access,
  input  wire logic [emesh_pkg::packet_width-1:0] pop_packet,
  output logic dec_valid,
  output logic dec_write,
  output logic [1:0] dec_datamode,
  output logic [emesh_pkg::ctrl_width-1:0] dec_ctrlmode,
  output logic [emesh_pkg::mem_index_width-1:0] dec_index,
  output logic [emesh_pkg::lane_count-1:0] dec_lane_mask,
  output logic [emesh_pkg::mem_width-1:0] dec_wdata,
  output logic [emesh_pkg::addr_width-1:0] dec_srcaddr,
  output logic dec_hit
);

  emesh_pkg::emesh_packet_t pkt_q;
  logic [2:0] byte_off;

  // Packet is consumed whenever the stage is not frozen
  always_ff @(posedge clk_out) begin
    if (reset_out) begin
      dec_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= pop_access;
    end
  end

  always_ff @(posedge clk_out) begin
    if (!stall && pop_access) begin
      pkt_q <= pop_packet;
    end
  end

  // Common fields
  assign dec_write = pkt_q.plain.write;
  assign dec_datamode = pkt_q.plain.datamode;
  assign dec_ctrlmode = pkt_q.plain.ctrlmode;
  assign dec_srcaddr = pkt_q.plain.srcaddr;
  assign byte_off = pkt_q.plain.dstaddr[2:0];

  // Window hit on the top address bits
  assign dec_hit = (pkt_q.plain.dstaddr[emesh_pkg::addr_width-1 -: emesh_pkg::win_width]
                    == emesh_pkg::core_base);
  assign dec_index = pkt_q.plain.dstaddr[emesh_pkg::idx_lsb +: emesh_pkg::mem_index_width];

  // Lane mask and write word per datamode
  always_comb begin
    case (pkt_q.plain.datamode)
      emesh_pkg::dm_byte: begin
        dec_lane_mask = 8'b0000_0001 << byte_off;
        dec_wdata = {8{pkt_q.plain.data[7:0]}};
      end
      emesh_pkg::dm_half: begin
        dec_lane_mask = 8'b0000_0011 << {byte_off[2:1], 1'b0};
        dec_wdata = {4{pkt_q.plain.data[15:0]}};
      end
      emesh_pkg::dm_word: begin
        dec_lane_mask = 8'b0000_1111 << {byte_off[2], 2'b00};
        dec_wdata = {2{pkt_q.plain.data}};
      end
      default: begin
        // Double, upper word comes from the srcaddr slot
        dec_lane_mask = '1;
        dec_wdata = pkt_q.dbl.data64;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/emesh_mem_exec.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_mem_exec (
  input  wire logic clk_out,
  input  wire logic reset_out,
  input  wire logic stall,
  input  wire logic dec_valid,
  input  wire logic dec_write,
  input  wire logic [1:0] dec_datamode,
  input  wire logic [emesh_pkg::ctrl_width-1:0] dec_ctrlmode,
  input  wire logic [emesh_pkg::mem_index_width-1:0] dec_index,
  input  wire logic [emesh_pkg::lane_count-1:0] dec_lane_mask,
  input  wire logic [emesh_pkg::mem_width-1:0] dec_wdata,
  input  wire logic [emesh_pkg::addr_width-1:0] dec_srcaddr,
  input  wire logic dec_hit,
  output logic rd_valid,
  output logic [emesh_pkg::mem_width-1:0] rd_data,
  output logic [emesh_pkg::addr_width-1:0] rd_srcaddr,
  output logic [emesh_pkg::ctrl_width-1:0] rd_ctrlmode,
  output logic [1:0] rd_datamode
);

  // Local memory, one 64-bit word per index
  logic [emesh_pkg::mem_width-1:0] mem [0:emesh_pkg::mem_depth-1];

  logic wr_fire;
  logic rd_fire;
  logic [2:0] lane_off;

  // Misses fall through with no effect
  assign wr_fire = ~stall & dec_valid & dec_hit & dec_write;
  assign rd_fire = ~stall & dec_valid & dec_hit & ~dec_write;

  // Lowest enabled lane gives the byte offset of the access
  always_comb begin
    lane_off = '0;
    for (int i = emesh_pkg::lane_count - 1; i >= 0; i--) begin
      if (dec_lane_mask[i]) begin
        lane_off = i[2:0];
      end
    end
  end

  // Masked byte writes
  always_ff @(posedge clk_out) begin
    if (wr_fire) begin
      for (int i = 0; i < emesh_pkg::lane_count; i++) begin
        if (dec_lane_mask[i]) begin
          mem[dec_index][i*8 +: 8] <= dec_wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_out) begin
    if (reset_out) begin
      rd_valid <= 1'b0;
    end else if (!stall) begin
      rd_valid <= dec_valid & dec_hit & ~dec_write;
    end
  end

  // Whole word, addressed lane moved down to bit 0
  always_ff @(posedge clk_out) begin
    if (rd_fire) begin
      rd_data <= mem[dec_index] >> {lane_off, 3'b000};
      rd_srcaddr <= dec_srcaddr;
      rd_ctrlmode <= dec_ctrlmode;
      rd_datamode <= dec_datamode;
    end
  end

endmodule

`default_nettype wire

//--- design/emesh_resp.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_resp (
  input  wire logic clk_out,
  input  wire logic reset_out,
  input  wire logic resp_wait,
  input  wire logic rd_valid,
  input  wire logic [emesh_pkg::mem_width-1:0] rd_data,
  input  wire logic [emesh_pkg::addr_width-1:0] rd_srcaddr,
  input  wire logic [emesh_pkg::ctrl_width-1:0] rd_ctrlmode,
  input  wire logic [1:0] rd_datamode,
  output logic resp_access,
  output logic [emesh_pkg::packet_width-1:0] resp_packet,
  output logic stall
);

  emesh_pkg::emesh_packet_t resp_next;
  emesh_pkg::emesh_packet_t resp_q;

  // Pending response not taken freezes the whole pipe
  assign stall = resp_access & resp_wait;
  assign resp_packet = resp_q;

  // Response is a write back to the requester
  always_comb begin
    resp_next = '0;
    resp_next.plain.write = 1'b1;
    resp_next.plain.datamode = rd_datamode;
    resp_next.plain.ctrlmode = rd_ctrlmode;
    resp_next.plain.dstaddr = rd_srcaddr;
    case (rd_datamode)
      emesh_pkg::dm_byte: resp_next.plain.data = {24'd0, rd_data[7:0]};
      emesh_pkg::dm_half: resp_next.plain.data = {16'd0, rd_data[15:0]};
      emesh_pkg::dm_word: resp_next.plain.data = rd_data[emesh_pkg::data_width-1:0];
      default: resp_next.dbl.data64 = rd_data;
    endcase
  end

  always_ff @(posedge clk_out) begin
    if (reset_out) begin
      resp_access <= 1'b0;
    end else if (!stall) begin
      resp_access <= rd_valid;
    end
  end

  // Packet held while waiting
  always_ff @(posedge clk_out) begin
    if (!stall && rd_valid) begin
      resp_q <= resp_next;
    end
  end

endmodule

`default_nettype wire

//--- design/emesh_elink_rx.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_elink_rx (
  // Mesh input, clk_in domain
  input  wire logic clk_in,
  input  wire logic reset_in,
  input  wire logic access_in,
  input  wire logic [emesh_pkg::packet_width-1:0] packet_in,
  output logic wait_out,
  // Core side, clk_out domain
  input  wire logic clk_out,
  input  wire logic reset_out,
  output logic resp_access,
  output logic [emesh_pkg::packet_width-1:0] resp_packet,
  input  wire logic resp_wait
);

  // Crossing output
  logic pop_access;
  logic [emesh_pkg::packet_width-1:0] pop_packet;
  logic stall;

  // Decode stage
  logic dec_valid;
  logic dec_write;
  logic [1:0] dec_datamode;
  logic [emesh_pkg::ctrl_width-1:0] dec_ctrlmode;
  logic [emesh_pkg::mem_index_width-1:0] dec_index;
  logic [emesh_pkg::lane_count-1:0] dec_lane_mask;
  logic [emesh_pkg::mem_width-1:0] dec_wdata;
  logic [emesh_pkg::addr_width-1:0] dec_srcaddr;
  logic dec_hit;

  // Execute stage
  logic rd_valid;
  logic [emesh_pkg::mem_width-1:0] rd_data;
  logic [emesh_pkg::addr_width-1:0] rd_srcaddr;
  logic [emesh_pkg::ctrl_width-1:0] rd_ctrlmode;
  logic [1:0] rd_datamode;

  // Stall doubles as the pop wait
  fifo_cdc i_fifo_cdc (
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .access_in  (access_in),
    .packet_in  (packet_in),
    .wait_out   (wait_out),
    .clk_out    (clk_out),
    .reset_out  (reset_out),
    .access_out (pop_access),
    .packet_out (pop_packet),
    .wait_in    (stall)
  );

  emesh_decode i_emesh_decode (
    .clk_out       (clk_out),
    .reset_out     (reset_out),
    .stall         (stall),
    .pop_access    (pop_access),
    .pop_packet    (pop_packet),
    .dec_valid     (dec_valid),
    .dec_write     (dec_write),
    .dec_datamode  (dec_datamode),
    .dec_ctrlmode  (dec_ctrlmode),
    .dec_index     (dec_index),
    .dec_lane_mask (dec_lane_mask),
    .dec_wdata     (dec_wdata),
    .dec_srcaddr   (dec_srcaddr),
    .dec_hit       (dec_hit)
  );

  emesh_mem_exec i_emesh_mem_exec (
    .clk_out       (clk_out),
    .reset_out     (reset_out),
    .stall         (stall),
    .dec_valid     (dec_valid),
    .dec_write     (dec_write),
    .dec_datamode  (dec_datamode),
    .dec_ctrlmode  (dec_ctrlmode),
    .dec_index     (dec_index),
    .dec_lane_mask (dec_lane_mask),
    .dec_wdata     (dec_wdata),
    .dec_srcaddr   (dec_srcaddr),
    .dec_hit       (dec_hit),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .rd_srcaddr    (rd_srcaddr),
    .rd_ctrlmode   (rd_ctrlmode),
    .rd_datamode   (rd_datamode)
  );

  emesh_resp i_emesh_resp (
    .clk_out     (clk_out),
    .reset_out   (reset_out),
    .resp_wait   (resp_wait),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_srcaddr  (rd_srcaddr),
    .rd_ctrlmode (rd_ctrlmode),
    .rd_datamode (rd_datamode),
    .resp_access (resp_access),
    .resp_packet (resp_packet),
    .stall       (stall)
  );

endmodule

`default_nettype wire

//--- verif/tb_emesh_elink_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_emesh_elink_rx;

  logic clk_in;
  logic reset_in;
  logic access_in;
  logic [emesh_pkg::packet_width-1:0] packet_in;
  logic wait_out;
  logic clk_out;
  logic reset_out;
  logic resp_access;
  logic [emesh_pkg::packet_width-1:0] resp_packet;
  logic resp_wait;

  // One stimulus table entry per file line
  int t_id[$];
  int t_write[$];
  int t_dm[$];
  logic [31:0] t_dst[$];
  logic [31:0] t_data[$];
  logic [31:0] t_src[$];
  logic [63:0] t_exp[$];

  // Expected responses in request order
  emesh_pkg::emesh_packet_t exp_q[$];

  int error_count;
  int check_count;
  int test_pass;
  int test_fail;
  int cur_test;
  logic wait_seen;
  logic loaded;
  // All requests of the current test handed to the DUT
  logic issue_done;

  emesh_elink_rx i_emesh_elink_rx (
    .clk_in      (clk_in),
    .reset_in    (reset_in),
    .access_in   (access_in),
    .packet_in   (packet_in),
    .wait_out    (wait_out),
    .clk_out     (clk_out),
    .reset_out   (reset_out),
    .resp_access (resp_access),
    .resp_packet (resp_packet),
    .resp_wait   (resp_wait)
  );

  // Core clock with a 100 ns period
  initial begin
    clk_out = 1'b0;
    forever #50 clk_out = ~clk_out;
  end

  // Mesh clock at an unrelated 70 ns period
  initial begin
    clk_in = 1'b0;
    forever #35 clk_in = ~clk_in;
  end

  task automatic check_value(input string name,
                             input logic [emesh_pkg::packet_width-1:0] actual,
                             input logic [emesh_pkg::packet_width-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Lines starting with # fail the scan and are skipped
  task automatic load_stimulus();
    int fd;
    int code;
    int id;
    int wr;
    int dm;
    logic [31:0] dst;
    logic [31:0] dat;
    logic [31:0] src;
    logic [63:0] expv;
    string line;
    fd = $fopen("verif/emesh_stimulus.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the stimulus file verif/emesh_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        code = $sscanf(line, "%d %d %d %h %h %h %h", id, wr, dm, dst, dat, src, expv);
        if (code == 7) begin
          t_id.push_back(id);
          t_write.push_back(wr);
          t_dm.push_back(dm);
          t_dst.push_back(dst);
          t_data.push_back(dat);
          t_src.push_back(src);
          t_exp.push_back(expv);
        end
      end
      $fclose(fd);
    end
  endtask

  // Hold access and packet until accepted on a clk_in edge without wait
  task automatic send_packet(input emesh_pkg::emesh_packet_t pkt);
    logic was_wait;
    @(posedge clk_in);
    #5;
    access_in = 1'b1;
    packet_in = pkt;
    do begin
      @(negedge clk_in);
      was_wait = wait_out;
      if (was_wait) begin
        wait_seen = 1'b1;
      end
      @(posedge clk_in);
    end while (was_wait);
    #5;
    access_in = 1'b0;
  endtask

  task automatic issue_line(input int n);
    emesh_pkg::emesh_packet_t req;
    emesh_pkg::emesh_packet_t exp_pkt;
    req = '0;
    req.plain.write = 1'(t_write[n]);
    req.plain.datamode = 2'(t_dm[n]);
    req.plain.ctrlmode = 4'(cur_test);
    req.plain.dstaddr = t_dst[n];
    req.plain.data = t_data[n];
    req.plain.srcaddr = t_src[n];
    // Only reads inside the window answer
    if (t_write[n] == 0 && t_dst[n][31:20] == emesh_pkg::core_base) begin
      exp_pkt = '0;
      exp_pkt.plain.write = 1'b1;
      exp_pkt.plain.datamode = req.plain.datamode;
      exp_pkt.plain.ctrlmode = req.plain.ctrlmode;
      exp_pkt.plain.dstaddr = t_src[n];
      exp_pkt.dbl.data64 = t_exp[n];
      exp_q.push_back(exp_pkt);
    end
    send_packet(req);
  endtask

  task automatic finish_test(input int errs_before);
    issue_done = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk_out);
    end
    if (cur_test == 6) begin
      check_value("wait_out", wait_seen, 1'b1);
    end
    if (error_count == errs_before) begin
      test_pass++;
      $display("Test %0d passed", cur_test);
    end else begin
      test_fail++;
      $display("Test %0d failed with %0d errors", cur_test, error_count - errs_before);
    end
  endtask

  // Random back-pressure in test 5
  // Test 6 holds it until the FIFO fills or the burst is all sent
  initial begin
    void'($urandom(81));
    resp_wait = 1'b0;
    forever begin
      @(posedge clk_out);
      #5;
      if (cur_test == 5) begin
        resp_wait = 1'($urandom % 2);
      end else if (cur_test == 6) begin
        resp_wait = ~wait_seen & ~issue_done;
      end else begin
        resp_wait = 1'b0;
      end
    end
  end

  // Response monitor sampled mid-cycle
  initial begin
    logic held;
    emesh_pkg::emesh_packet_t held_pkt;
    emesh_pkg::emesh_packet_t pkt;
    emesh_pkg::emesh_packet_t exp_pkt;
    held = 1'b0;
    forever begin
      @(negedge clk_out);
      pkt = resp_packet;
      // Held response must not move
      if (held) begin
        check_value("resp_access", resp_access, 1'b1);
        check_value("resp_packet", pkt, held_pkt);
      end
      // Taken at the coming edge
      if (resp_access === 1'b1 && resp_wait === 1'b0) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("A response arrived at %0t with no read outstanding", $time);
        end else begin
          exp_pkt = exp_q.pop_front();
          check_value("resp_packet.dstaddr", pkt.plain.dstaddr, exp_pkt.plain.dstaddr);
          check_value("resp_packet.data64", pkt.dbl.data64, exp_pkt.dbl.data64);
          check_value("resp_packet.header", pkt[6:0], exp_pkt[6:0]);
        end
      end
      held = (resp_access === 1'b1) && (resp_wait === 1'b1);
      held_pkt = pkt;
    end
  end

  // Watchdog scaled by stimulus length
  initial begin
    wait (loaded);
    repeat (t_id.size() * 200 + 1000) @(posedge clk_out);
    $display("Timeout: responses or FIFO acceptance did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int n;
    int errs_before;
    $timeformat(-9, 0, " ns", 0);
    access_in = 1'b0;
    packet_in = '0;
    reset_in = 1'b1;
    reset_out = 1'b1;
    error_count = 0;
    check_count = 0;
    test_pass = 0;
    test_fail = 0;
    cur_test = 0;
    wait_seen = 1'b0;
    issue_done = 1'b0;
    errs_before = 0;
    loaded = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    // Both domains in reset for two core cycles
    repeat (2) @(posedge clk_out);
    #5;
    reset_out = 1'b0;
    reset_in = 1'b0;
    // Idle outputs once reset is done
    check_value("resp_access", resp_access, 1'b0);
    check_value("wait_out", wait_out, 1'b0);
    for (n = 0; n < t_id.size(); n++) begin
      // New test id closes the previous test
      if (t_id[n] != cur_test) begin
        if (cur_test != 0) begin
          finish_test(errs_before);
        end
        issue_done = 1'b0;
        cur_test = t_id[n];
        wait_seen = 1'b0;
        errs_before = error_count;
      end
      issue_line(n);
    end
    if (cur_test != 0) begin
      finish_test(errs_before);
    end
    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             test_pass, test_fail, check_count, error_count);
    if (error_count == 0 && test_fail == 0 && t_id.size() > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/emesh_stimulus.txt
# test write datamode dstaddr data srcaddr expected_read_data (hex from dstaddr on)
# datamode 0 byte, 1 half, 2 word, 3 double; expected is 0 for writes and missed reads
1 1 2 81000010 11223344 00000000 0
1 1 2 81000014 55667788 00000000 0
1 0 2 81000010 00000000 00a00001 11223344
1 0 2 81000014 00000000 00a00002 55667788
2 1 0 81000011 000000ab 00000000 0
2 1 1 81000016 0000cdef 00000000 0
2 0 0 81000011 00000000 00a00011 ab
2 0 0 81000017 00000000 00a00012 cd
2 0 1 81000016 00000000 00a00013 cdef
2 0 1 81000012 00000000 00a00014 1122
2 0 2 81000010 00000000 00a00015 1122ab44
3 1 3 81000020 89abcdef 01234567 0
3 0 3 81000020 00000000 00a00021 0123456789abcdef
3 0 2 81000024 00000000 00a00022 01234567
4 1 2 82000010 deadbeef 00000000 0
4 0 2 82000010 00000000 00a00031 0
4 0 2 81000010 00000000 00a00032 1122ab44
4 0 2 81000014 00000000 00a00033 cdef7788
5 0 2 81000014 00000000 00a00041 cdef7788
5 0 3 81000020 00000000 00a00042 0123456789abcdef
5 0 0 81000016 00000000 00a00043 ef
5 0 1 81000010 00000000 00a00044 ab44
5 0 2 81000024 00000000 00a00045 01234567
5 0 2 81000010 00000000 00a00046 1122ab44
5 0 0 81000022 00000000 00a00047 ab
6 0 2 81000010 00000000 00b00001 1122ab44
6 0 2 81000014 00000000 00b00002 cdef7788
6 0 2 81000020 00000000 00b00003 89abcdef
6 0 2 81000024 00000000 00b00004 01234567
6 0 2 81000010 00000000 00b00005 1122ab44
6 0 2 81000014 00000000 00b00006 cdef7788
6 0 2 81000020 00000000 00b00007 89abcdef
6 0 2 81000024 00000000 00b00008 01234567
6 0 2 81000010 00000000 00b00009 1122ab44
6 0 2 81000014 00000000 00b0000a cdef7788
6 0 2 81000020 00000000 00b0000b 89abcdef
6 0 2 81000024 00000000 00b0000c 01234567
6 0 2 81000010 00000000 00b0000d 1122ab44
6 0 2 81000014 00000000 00b0000e cdef7788
6 0 2 81000020 00000000 00b0000f 89abcdef
6 0 2 81000024 00000000 00b00010 01234567
6 0 2 81000010 00000000 00b00011 1122ab44
6 0 2 81000014 00000000 00b00012 cdef7788
6 0 2 81000020 00000000 00b00013 89abcdef
6 0 2 81000024 00000000 00b00014 01234567
6 0 2 81000010 00000000 00b00015 1122ab44
6 0 2 81000014 00000000 00b00016 cdef7788

//--- filelist.f
design/emesh_pkg.sv
design/fifo_async.sv
design/fifo_cdc.sv
design/emesh_decode.sv
design/emesh_mem_exec.sv
design/emesh_resp.sv
design/emesh_elink_rx.sv
verif/tb_emesh_elink_rx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_emesh_elink_rx
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
